// File: common/ion_sample_table.svh
// recorded ion sensor packets as a constant table
`ifndef ION_SAMPLE_TABLE_SVH
`define ION_SAMPLE_TABLE_SVH

// fields in struct order from serial down to device_id
localparam ion_pkg::ion_packet_t SAMPLE_TABLE [ion_pkg::SAMPLE_COUNT] = '{
	'{24'd4272433, 6'd1, 16'd3791, 8'd17, 8'd239, 16'd925, 8'd100, 8'd176, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd63275, 8'd17, 8'd239, 16'd962, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd24574, 8'd17, 8'd239, 16'd1011, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd40019, 8'd17, 8'd239, 16'd1045, 8'd100, 8'd185, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd50527, 8'd17, 8'd239, 16'd1094, 8'd100, 8'd186, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd60177, 8'd17, 8'd239, 16'd1136, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd47222, 8'd17, 8'd239, 16'd1178, 8'd100, 8'd178, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd42756, 8'd17, 8'd239, 16'd1220, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd61961, 8'd17, 8'd239, 16'd1262, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd7993, 8'd17, 8'd239, 16'd1304, 8'd100, 8'd183, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd17675, 8'd17, 8'd239, 16'd1346, 8'd100, 8'd178, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd57473, 8'd17, 8'd239, 16'd1380, 8'd100, 8'd178, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd53224, 8'd17, 8'd239, 16'd1430, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd61195, 8'd17, 8'd239, 16'd1472, 8'd100, 8'd178, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd46996, 8'd17, 8'd239, 16'd1514, 8'd100, 8'd185, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd145, 8'd17, 8'd239, 16'd1556, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd21191, 8'd17, 8'd239, 16'd1598, 8'd100, 8'd178, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd610, 8'd17, 8'd239, 16'd1635, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd4089, 8'd17, 8'd239, 16'd1679, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd20685, 8'd17, 8'd239, 16'd1729, 8'd100, 8'd178, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd10459, 8'd17, 8'd239, 16'd1766, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd57766, 8'd17, 8'd239, 16'd1815, 8'd100, 8'd178, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd48236, 8'd17, 8'd239, 16'd1857, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd36453, 8'd17, 8'd239, 16'd1903, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd22977, 8'd17, 8'd239, 16'd1945, 8'd100, 8'd183, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd13045, 8'd17, 8'd239, 16'd1987, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd40993, 8'd17, 8'd239, 16'd2033, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77},
	'{24'd4272433, 6'd1, 16'd45310, 8'd17, 8'd239, 16'd2075, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd62988, 8'd17, 8'd239, 16'd2108, 8'd100, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd50032, 8'd17, 8'd239, 16'd2162, 8'd101, 8'd177, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd22312, 8'd17, 8'd239, 16'd2199, 8'd100, 8'd178, 8'd255, 1'b1, 7'd77},
	'{24'd4272433, 6'd1, 16'd48507, 8'd17, 8'd239, 16'd2248, 8'd100, 8'd177, 8'd255, 1'b0, 7'd77}
};

`endif

// File: common/ion_pkg.sv
// ion sensor packet field types, packet struct, table and pacing constants, sequencer states
package ion_pkg;

	// recorded sample table
	localparam int SAMPLE_COUNT = 32;
	localparam int SAMPLE_INDEX_WIDTH = $clog2(SAMPLE_COUNT);

	// pacing interval in clock cycles
	localparam int PACKET_INTERVAL = 16;
	// the count steps one past the interval and holds there
	localparam int INTERVAL_COUNT_WIDTH = $clog2(PACKET_INTERVAL + 2);

	typedef logic [SAMPLE_INDEX_WIDTH-1:0] sample_index_t;
	typedef logic [INTERVAL_COUNT_WIDTH-1:0] interval_count_t;

	// packet fields
	typedef logic [6:0] device_id_t;
	typedef logic polarity_t;
	typedef logic [7:0] marker_t;
	// slowly varying sensor value
	typedef logic [7:0] reading_t;
	typedef logic [7:0] level_t;
	// increases from packet to packet
	typedef logic [15:0] timestamp_t;
	typedef logic [7:0] config_a_t;
	typedef logic [7:0] config_b_t;
	// varying measurement word
	typedef logic [15:0] payload_t;
	typedef logic [5:0] channel_t;
	typedef logic [23:0] serial_t;

	// 110 bits, serial on top and device_id at bit 0
	typedef struct packed {
		serial_t serial;
		channel_t channel;
		payload_t payload;
		config_b_t config_b;
		config_a_t config_a;
		timestamp_t timestamp;
		level_t level;
		reading_t reading;
		marker_t marker;
		polarity_t polarity;
		device_id_t device_id;
	} ion_packet_t;

	typedef enum logic [1:0]
	{
		state_idle,
		state_fetch,
		state_send
	} seq_state_t;

endpackage

// File: hw/ion_pacing_timer.sv
// restartable pacing interval counter with a one-cycle due pulse
`timescale 1ns/10ps

module ion_pacing_timer
(
	input logic clock,
	input logic resetn,
	input logic interval_restart,
	output logic interval_done
);

	ion_pkg::interval_count_t interval_count;
	ion_pkg::interval_count_t interval_count_next;
	logic interval_counting;

	// stop one step past the interval so the due pulse lasts one cycle
	assign interval_counting =
		(interval_count != ion_pkg::interval_count_t'(ion_pkg::PACKET_INTERVAL + 1));

	always_comb
	begin
		interval_count_next = interval_count;
		if (interval_restart)
			// the transfer edge is the first pacing cycle, as the first edge out of reset
			interval_count_next = ion_pkg::interval_count_t'(1);
		else if (interval_counting)
			interval_count_next = interval_count + 1'b1;
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			interval_count <= '0;
		else
			interval_count <= interval_count_next;
	end

	assign interval_done =
		(interval_count == ion_pkg::interval_count_t'(ion_pkg::PACKET_INTERVAL));

endmodule

// File: hw/packet_source/ion_sample_rom.sv
// registered lookup of one recorded packet from the sample table
`timescale 1ns/10ps

module ion_sample_rom
(
	input logic clock,
	input logic fetch_enable,
	input ion_pkg::sample_index_t sample_index,
	output ion_pkg::ion_packet_t sample_packet
);

	`include "ion_sample_table.svh"

	// one cycle read latency, block memory friendly
	always_ff @(posedge clock)
	begin
		if (fetch_enable)
			sample_packet <= SAMPLE_TABLE[sample_index];
	end

endmodule

// File: hw/packet_source/ion_packet_sequencer.sv
// idle, fetch and send FSM with the table index and the packet handshake
`timescale 1ns/10ps

module ion_packet_sequencer
(
	input logic clock,
	input logic resetn,

	// pacing timer
	input logic interval_done,
	output logic interval_restart,

	// sample table
	output logic fetch_enable,
	output ion_pkg::sample_index_t sample_index,
	input ion_pkg::ion_packet_t sample_packet,

	// packet output
	output logic packet_valid,
	input logic packet_ready,
	output ion_pkg::ion_packet_t packet
);

	ion_pkg::seq_state_t state;
	ion_pkg::seq_state_t state_next;
	ion_pkg::sample_index_t index;
	ion_pkg::sample_index_t index_next;
	logic transfer;
	logic index_last;

	assign transfer = packet_valid && packet_ready;

	always_comb
	begin
		state_next = state;
		case (state)
			ion_pkg::state_idle:
			begin
				if (interval_done)
					state_next = ion_pkg::state_fetch;
			end
			ion_pkg::state_fetch:
			begin
				// table answers at the end of this cycle
				state_next = ion_pkg::state_send;
			end
			ion_pkg::state_send:
			begin
				if (packet_ready)
					state_next = ion_pkg::state_idle;
			end
			default:
			begin
				state_next = ion_pkg::state_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state <= ion_pkg::state_idle;
		else
			state <= state_next;
	end

	// step through the recorded packets in order, wrap after the last
	assign index_last = (index == ion_pkg::sample_index_t'(ion_pkg::SAMPLE_COUNT - 1));

	always_comb
	begin
		index_next = index;
		if (transfer)
		begin
			if (index_last)
				index_next = '0;
			else
				index_next = index + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			index <= '0;
		else
			index <= index_next;
	end

	assign fetch_enable = (state == ion_pkg::state_fetch);
	assign sample_index = index;

	assign packet_valid = (state == ion_pkg::state_send);
	// table output stays put until the next fetch, so it holds through a stall
	assign packet = sample_packet;

	// next interval starts at the transfer
	assign interval_restart = transfer;

endmodule

// File: hw/ion_sensor_top.sv
// ion sensor packet simulator top with pacing timer, sequencer and sample table
`timescale 1ns/10ps

module ion_sensor_top
(
	input logic clock,
	input logic resetn,
	output logic packet_valid,
	input logic packet_ready,
	output ion_pkg::ion_packet_t packet
);

	logic interval_done;
	logic interval_restart;
	logic fetch_enable;
	ion_pkg::sample_index_t sample_index;
	ion_pkg::ion_packet_t sample_packet;

	ion_pacing_timer u_pacing_timer
	(
		.clock (clock),
		.resetn (resetn),
		.interval_restart (interval_restart),
		.interval_done (interval_done)
	);

	ion_packet_sequencer u_packet_sequencer
	(
		.clock (clock),
		.resetn (resetn),
		.interval_done (interval_done),
		.interval_restart (interval_restart),
		.fetch_enable (fetch_enable),
		.sample_index (sample_index),
		.sample_packet (sample_packet),
		.packet_valid (packet_valid),
		.packet_ready (packet_ready),
		.packet (packet)
	);

	// recorded packets, read one cycle after fetch_enable
	ion_sample_rom u_sample_rom
	(
		.clock (clock),
		.fetch_enable (fetch_enable),
		.sample_index (sample_index),
		.sample_packet (sample_packet)
	);

endmodule

// File: bench/ion_sensor_tb.sv
// testbench for the ion sensor packet simulator with pattern checks, back-pressure and timeout
`timescale 1ns/10ps

module ion_sensor_tb;

	localparam int PATTERN_COUNT = 40;
	localparam int RESET_CYCLES = 16;
	// sample after the starting edge is cycle 1
	localparam int RISE_CYCLES = ion_pkg::PACKET_INTERVAL + 2;
	localparam int CYCLE_LIMIT = PATTERN_COUNT * (ion_pkg::PACKET_INTERVAL + 2 + 8) + 64;

	logic clock;
	logic resetn;
	logic packet_valid;
	logic packet_ready;
	ion_pkg::ion_packet_t packet;

	// stall count in the top byte, packet in the low 110 bits
	logic [119:0] patterns [PATTERN_COUNT];

	integer seed;
	int cycle_count;
	int error_count;
	int check_count;
	int test_count;
	int test_fail_count;

	ion_sensor_top u_ion_sensor_top
	(
		.clock (clock),
		.resetn (resetn),
		.packet_valid (packet_valid),
		.packet_ready (packet_ready),
		.packet (packet)
	);

	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// outputs have settled 1 ns after the edge, inputs change there too
	task automatic next_cycle;
		@(posedge clock);
		#1;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count != errors_before)
		begin
			test_fail_count++;
			$display("test %s: failed", name);
		end
		else
			$display("test %s: ok", name);
	endtask

	task automatic check_packet(input string name, input ion_pkg::ion_packet_t expected);
		compare({name, ".packet"}, expected, packet);
		compare({name, ".serial"}, expected.serial, packet.serial);
		compare({name, ".channel"}, expected.channel, packet.channel);
		compare({name, ".payload"}, expected.payload, packet.payload);
		compare({name, ".config_b"}, expected.config_b, packet.config_b);
		compare({name, ".config_a"}, expected.config_a, packet.config_a);
		compare({name, ".timestamp"}, expected.timestamp, packet.timestamp);
		compare({name, ".level"}, expected.level, packet.level);
		compare({name, ".reading"}, expected.reading, packet.reading);
		compare({name, ".marker"}, expected.marker, packet.marker);
		compare({name, ".polarity"}, expected.polarity, packet.polarity);
		compare({name, ".device_id"}, expected.device_id, packet.device_id);
	endtask

	// called at cycle 1 of an interval, returns the cycle where valid is seen high
	task automatic wait_for_valid(output int elapsed);
		elapsed = 1;
		while (packet_valid !== 1'b1)
		begin
			next_cycle();
			elapsed++;
		end
	endtask

	task automatic run_reset;
		int errors_before;
		errors_before = error_count;
		repeat (RESET_CYCLES)
		begin
			next_cycle();
			compare("reset.valid", 1'b0, packet_valid);
		end
		resetn = 1'b1;
		// first edge with resetn high starts the first interval
		next_cycle();
		report_test("reset", errors_before);
	endtask

	task automatic run_packet(input int n);
		string name;
		ion_pkg::ion_packet_t expected;
		int stall;
		int elapsed;
		int errors_before;
		errors_before = error_count;
		if (n >= ion_pkg::SAMPLE_COUNT)
			name = $sformatf("wrap_%0d", n);
		else
			name = $sformatf("packet_%0d", n);
		expected = patterns[n][109:0];
		stall = patterns[n][119:112];
		if (stall == 0)
			stall = $unsigned($random(seed)) % 4;

		wait_for_valid(elapsed);
		compare({name, ".rise_cycles"}, RISE_CYCLES, elapsed);

		// the offer stays put while the consumer holds off
		repeat (stall)
		begin
			next_cycle();
			compare({name, ".hold_valid"}, 1'b1, packet_valid);
			compare({name, ".hold_packet"}, expected, packet);
		end

		check_packet(name, expected);
		packet_ready = 1'b1;
		next_cycle();
		packet_ready = 1'b0;
		report_test(name, errors_before);
	endtask

	initial
	begin
		clock = 1'b0;
		resetn = 1'b0;
		packet_ready = 1'b0;
		seed = 32'hb3409042;
		cycle_count = 0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		test_fail_count = 0;

		$readmemh("bench/ion_patterns.txt", patterns);
		if ($isunknown(patterns[PATTERN_COUNT-1]))
		begin
			error_count++;
			$display("the pattern file bench/ion_patterns.txt could not be read in full");
		end

		run_reset();
		for (int n = 0; n < PATTERN_COUNT; n++)
			run_packet(n);

		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			test_count, test_fail_count, check_count, error_count);
		if (error_count == 0 && test_fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: bench/ion_patterns.txt
// column 1 is the stall before ready (00 picks 0 to 3 at random)
// column 2 is the packet in hex from serial and channel down to polarity and device_id
00_104c4c41_0ecf_11ef_039d_64b0ff_cd
03_104c4c41_f72b_11ef_03c2_64b1ff_4d
00_104c4c41_5ffe_11ef_03f3_64b1ff_cd
01_104c4c41_9c53_11ef_0415_64b9ff_cd
07_104c4c41_c55f_11ef_0446_64baff_cd
00_104c4c41_eb11_11ef_0470_64b1ff_4d
02_104c4c41_b876_11ef_049a_64b2ff_4d
05_104c4c41_a704_11ef_04c4_64b1ff_4d
00_104c4c41_f209_11ef_04ee_64b1ff_4d
04_104c4c41_1f39_11ef_0518_64b7ff_4d
01_104c4c41_450b_11ef_0542_64b2ff_4d
00_104c4c41_e081_11ef_0564_64b2ff_4d
06_104c4c41_cfe8_11ef_0596_64b1ff_4d
02_104c4c41_ef0b_11ef_05c0_64b2ff_4d
00_104c4c41_b794_11ef_05ea_64b9ff_cd
03_104c4c41_0091_11ef_0614_64b1ff_cd
00_104c4c41_52c7_11ef_063e_64b2ff_cd
07_104c4c41_0262_11ef_0663_64b1ff_4d
01_104c4c41_0ff9_11ef_068f_64b1ff_cd
00_104c4c41_50cd_11ef_06c1_64b2ff_4d
05_104c4c41_28db_11ef_06e6_64b1ff_cd
02_104c4c41_e1a6_11ef_0717_64b2ff_cd
00_104c4c41_bc6c_11ef_0741_64b1ff_4d
04_104c4c41_8e65_11ef_076f_64b1ff_cd
00_104c4c41_59c1_11ef_0799_64b7ff_4d
03_104c4c41_32f5_11ef_07c3_64b1ff_4d
06_104c4c41_a021_11ef_07f1_64b1ff_4d
00_104c4c41_b0fe_11ef_081b_64b1ff_cd
01_104c4c41_f60c_11ef_083c_64b1ff_cd
02_104c4c41_c370_11ef_0872_65b1ff_cd
00_104c4c41_5728_11ef_0897_64b2ff_cd
05_104c4c41_bd7b_11ef_08c8_64b1ff_4d
// index wraps back to entry 0 here
00_104c4c41_0ecf_11ef_039d_64b0ff_cd
04_104c4c41_f72b_11ef_03c2_64b1ff_4d
00_104c4c41_5ffe_11ef_03f3_64b1ff_cd
07_104c4c41_9c53_11ef_0415_64b9ff_cd
02_104c4c41_c55f_11ef_0446_64baff_cd
00_104c4c41_eb11_11ef_0470_64b1ff_4d
01_104c4c41_b876_11ef_049a_64b2ff_4d
03_104c4c41_a704_11ef_04c4_64b1ff_4d

// File: sources.f
+incdir+common
common/ion_pkg.sv
hw/ion_pacing_timer.sv
hw/packet_source/ion_sample_rom.sv
hw/packet_source/ion_packet_sequencer.sv
hw/ion_sensor_top.sv
bench/ion_sensor_tb.sv

// File: Bender.yml
package:
  name: ion_sensor

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ion_pkg.sv
      - hw/ion_pacing_timer.sv
      - hw/packet_source/ion_sample_rom.sv
      - hw/packet_source/ion_packet_sequencer.sv
      - hw/ion_sensor_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - bench/ion_sensor_tb.sv
